// File: hw/mem_cfg_pkg.sv
package mem_cfg_pkg;

    // Result of a read that hits the word being written in the same cycle
    typedef enum logic [1:0] {
        RDW_DONT_CARE,
        RDW_OLD_DATA,
        RDW_NEW_DATA
    } rdw_mode_e;

endpackage

// File: hw/stream_pkg.sv
package stream_pkg;

    // Collector phase, idle until the first word shows up
    typedef enum logic {
        COLLECT_IDLE,
        COLLECT_DRAIN
    } collect_state_e;

    // Largest supported log2 lane count
    localparam int LANE_SEL_W_MAX = 3;

    // Lane-select register, sized for the largest lane count
    typedef logic [LANE_SEL_W_MAX-1:0] lane_sel_t;

endpackage

// File: hw/lane_if.sv
`timescale 1ns/1ns

interface lane_if #(
    parameter int WIDTH = 20
) ();
    logic             valid;
    logic             ready;
    logic [WIDTH-1:0] data;
    logic             last_pop;

    // Pulses on every accepted word
    assign last_pop = valid && ready;

    modport source (
        output valid,
        output data,
        input  ready,
        input  last_pop
    );

    modport sink (
        input  valid,
        input  data,
        output ready,
        input  last_pop
    );
endinterface

// File: hw/memory_mlab.sv
`timescale 1ns/1ns

module memory_mlab
    import mem_cfg_pkg::*;
#(
    parameter int        WIDTH             = 20,
    parameter int        DEPTH_LOG2        = 4,
    parameter rdw_mode_e READ_DURING_WRITE = RDW_OLD_DATA,
    parameter int        OUTPUT_REGISTER   = 1
) (
    input  logic                  clk,
    input  logic                  rstReadAddr,
    input  logic                  write_enable,
    input  logic [DEPTH_LOG2-1:0] write_addr,
    input  logic [WIDTH-1:0]      data_in,
    input  logic                  read_stall,
    input  logic [DEPTH_LOG2-1:0] read_addr,
    output logic [WIDTH-1:0]      data_out
);
    logic [WIDTH-1:0]      mem [1 << DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] write_addr_reg;
    logic [WIDTH-1:0]      write_data_reg;
    logic                  write_enable_reg;
    logic [DEPTH_LOG2-1:0] read_addr_reg;
    logic                  read_fresh;
    logic                  collision;
    logic [WIDTH-1:0]      data_from_mem;

    // Write goes through one register stage before the array
    always_ff @(posedge clk) begin
        if (write_enable_reg) begin
            mem[write_addr_reg] <= write_data_reg;
        end
        write_addr_reg <= write_addr;
        write_data_reg <= data_in;
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            write_enable_reg <= 1'b0;
            read_addr_reg    <= '0;
            read_fresh       <= 1'b0;
        end else begin
            write_enable_reg <= write_enable;
            read_fresh       <= !read_stall;
            if (!read_stall) begin
                read_addr_reg <= read_addr;
            end
        end
    end

    assign collision = write_enable_reg && (write_addr_reg == read_addr_reg);

    always_comb begin
        data_from_mem = mem[read_addr_reg];
        if (collision) begin
            case (READ_DURING_WRITE)
                RDW_DONT_CARE: data_from_mem = 'x;
                RDW_NEW_DATA:  data_from_mem = write_data_reg;
                default:       data_from_mem = mem[read_addr_reg];
            endcase
        end
    end

    if (OUTPUT_REGISTER != 0) begin : g_out_reg
        logic [WIDTH-1:0] data_out_reg;

        always_ff @(posedge clk) begin
            data_out_reg <= data_from_mem;
        end
        assign data_out = data_out_reg;
    end else begin : g_out_comb
        assign data_out = data_from_mem;
    end

    // A freshly taken read address must not meet a pending write here
    assert property (@(posedge clk) disable iff (rstReadAddr)
        !(READ_DURING_WRITE == RDW_DONT_CARE && read_fresh && collision))
        else $error("memory_mlab: read collides with pending write");
endmodule

// File: hw/lane_fifo.sv
`timescale 1ns/1ns

module lane_fifo
    import mem_cfg_pkg::*;
#(
    parameter int        WIDTH             = 20,
    parameter int        DEPTH_LOG2        = 4,
    parameter int        OUTPUT_REGISTER   = 1,
    parameter rdw_mode_e READ_DURING_WRITE = RDW_OLD_DATA
) (
    input logic    clk,
    input logic    rstReadAddr,
    lane_if.sink   in_lane,
    lane_if.source out_lane
);
    localparam int            LAT   = 1 + OUTPUT_REGISTER;
    localparam int            CW    = DEPTH_LOG2 + 1;
    localparam logic [CW-1:0] DEPTH = CW'(1 << DEPTH_LOG2);

    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [CW-1:0]         stored;
    logic [CW-1:0]         visible;
    logic                  push;
    logic                  push_q;
    logic                  pop;
    logic                  issue;
    logic                  land;
    logic [LAT-1:0]        in_flight;
    logic [1:0]            in_flight_cnt;
    logic [WIDTH-1:0]      mem_data;
    logic [WIDTH-1:0]      skid_data [2];
    logic                  skid_wr;
    logic                  skid_rd;
    logic [1:0]            skid_count;

    assign push          = in_lane.last_pop;
    assign pop           = out_lane.last_pop;
    assign in_lane.ready = (stored != DEPTH);
    assign land          = in_flight[LAT-1];
    assign in_flight_cnt = 2'($countones(in_flight));

    // Skid must hold every read in flight plus the new one
    assign issue = (visible != '0) &&
                   (3'(skid_count) + 3'(in_flight_cnt) < 3'd2 + 3'(pop));

    memory_mlab #(
        .WIDTH            (WIDTH),
        .DEPTH_LOG2       (DEPTH_LOG2),
        .READ_DURING_WRITE(READ_DURING_WRITE),
        .OUTPUT_REGISTER  (OUTPUT_REGISTER)
    ) u_mem (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .write_enable(push),
        .write_addr  (wr_ptr),
        .data_in     (in_lane.data),
        .read_stall  (!issue),
        .read_addr   (rd_ptr),
        .data_out    (mem_data)
    );

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            stored    <= '0;
            visible   <= '0;
            push_q    <= 1'b0;
            in_flight <= '0;
        end else begin
            push_q <= push;
            if (push) begin
                wr_ptr <= wr_ptr + DEPTH_LOG2'(1);
            end
            if (issue) begin
                rd_ptr <= rd_ptr + DEPTH_LOG2'(1);
            end
            stored <= stored + CW'(push) - CW'(issue);
            // Counts a word only once the write pipe has stored it
            visible   <= visible + CW'(push_q) - CW'(issue);
            in_flight <= LAT'({in_flight, issue});
        end
    end

    // Two-entry output skid
    always_ff @(posedge clk) begin
        if (land) begin
            skid_data[skid_wr] <= mem_data;
        end
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            skid_wr    <= 1'b0;
            skid_rd    <= 1'b0;
            skid_count <= '0;
        end else begin
            if (land) begin
                skid_wr <= !skid_wr;
            end
            if (pop) begin
                skid_rd <= !skid_rd;
            end
            skid_count <= skid_count + 2'(land) - 2'(pop);
        end
    end

    assign out_lane.valid = (skid_count != 2'd0);
    assign out_lane.data  = skid_data[skid_rd];

    // Equal pointers with a nonzero count means full
    assert property (@(posedge clk) disable iff (rstReadAddr)
        push |-> (wr_ptr != rd_ptr) || (stored == '0))
        else $error("lane_fifo: push while full");

    assert property (@(posedge clk) disable iff (rstReadAddr)
        land |-> (skid_count != 2'd2) || pop)
        else $error("lane_fifo: skid overflow");
endmodule

// File: hw/lane_distributor.sv
`timescale 1ns/1ns

module lane_distributor
    import stream_pkg::*;
#(
    parameter int WIDTH      = 20,
    parameter int LANES_LOG2 = 2
) (
    input  logic             clk,
    input  logic             rstReadAddr,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    lane_if.source           lanes [1 << LANES_LOG2]
);
    localparam int        LANES = 1 << LANES_LOG2;
    localparam lane_sel_t LAST  = lane_sel_t'(LANES - 1);

    lane_sel_t        sel;
    logic [LANES-1:0] hit;
    logic [LANES-1:0] ready_hit;
    logic [LANES-1:0] lane_pop;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign hit[i]         = (sel == lane_sel_t'(i));
        assign lanes[i].valid = in_valid && hit[i];
        assign lanes[i].data  = in_data;
        assign ready_hit[i]   = lanes[i].ready && hit[i];
        assign lane_pop[i]    = lanes[i].last_pop;
    end

    assign in_ready = |ready_hit;

    // Next lane after every accepted word
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            sel <= '0;
        end else if (|lane_pop) begin
            sel <= (sel == LAST) ? '0 : sel + lane_sel_t'(1);
        end
    end
endmodule

// File: hw/lane_collector.sv
`timescale 1ns/1ns

module lane_collector
    import stream_pkg::*;
#(
    parameter int WIDTH      = 20,
    parameter int LANES_LOG2 = 2
) (
    input  logic             clk,
    input  logic             rstReadAddr,
    lane_if.sink             lanes [1 << LANES_LOG2],
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);
    localparam int        LANES = 1 << LANES_LOG2;
    localparam lane_sel_t LAST  = lane_sel_t'(LANES - 1);

    lane_sel_t        sel;
    logic [LANES-1:0] hit;
    logic [LANES-1:0] valid_hit;
    logic [WIDTH-1:0] data_hit [LANES];
    logic             take;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign hit[i]         = (sel == lane_sel_t'(i));
        assign valid_hit[i]   = lanes[i].valid && hit[i];
        assign data_hit[i]    = hit[i] ? lanes[i].data : '0;
        assign lanes[i].ready = out_ready && hit[i];
    end

    assign out_valid = |valid_hit;
    assign take      = out_valid && out_ready;

    always_comb begin
        out_data = '0;
        for (int k = 0; k < LANES; k++) begin
            out_data = out_data | data_hit[k];
        end
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            sel <= '0;
        end else if (take) begin
            sel <= (sel == LAST) ? '0 : sel + lane_sel_t'(1);
        end
    end

    // Held word stays put until taken, which relies on the lane skid
    assert property (@(posedge clk) disable iff (rstReadAddr)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("lane_collector: output word changed while stalled");
endmodule

// File: hw/banked_fifo_top.sv
`timescale 1ns/1ns

module banked_fifo_top
    import mem_cfg_pkg::*;
#(
    parameter int        WIDTH             = 20,
    parameter int        DEPTH_LOG2        = 4,
    parameter int        LANES_LOG2        = 2,
    parameter int        OUTPUT_REGISTER   = 1,
    parameter rdw_mode_e READ_DURING_WRITE = RDW_OLD_DATA
) (
    input  logic             clk,
    input  logic             rstReadAddr,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);
    localparam int LANES = 1 << LANES_LOG2;

    lane_if #(.WIDTH(WIDTH)) in_lanes  [LANES] ();
    lane_if #(.WIDTH(WIDTH)) out_lanes [LANES] ();

    lane_distributor #(
        .WIDTH     (WIDTH),
        .LANES_LOG2(LANES_LOG2)
    ) u_dist (
        .clk        (clk),
        .rstReadAddr(rstReadAddr),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .lanes      (in_lanes)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_fifo #(
            .WIDTH            (WIDTH),
            .DEPTH_LOG2       (DEPTH_LOG2),
            .OUTPUT_REGISTER  (OUTPUT_REGISTER),
            .READ_DURING_WRITE(READ_DURING_WRITE)
        ) u_fifo (
            .clk        (clk),
            .rstReadAddr(rstReadAddr),
            .in_lane    (in_lanes[i]),
            .out_lane   (out_lanes[i])
        );
    end

    lane_collector #(
        .WIDTH     (WIDTH),
        .LANES_LOG2(LANES_LOG2)
    ) u_coll (
        .clk        (clk),
        .rstReadAddr(rstReadAddr),
        .lanes      (out_lanes),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );
endmodule

// File: testbench/tb_banked_fifo.sv
`timescale 1ns/1ns

module tb_banked_fifo
    import mem_cfg_pkg::*;
();
    localparam int WIDTH          = 20;
    localparam int DEPTH_LOG2     = 4;
    localparam int LANES_LOG2     = 2;
    localparam int CAPACITY       = (1 << LANES_LOG2) * (1 << DEPTH_LOG2);
    localparam int N_FREE         = 200;
    localparam int N_BACK         = 300;
    localparam int N_FILL         = 2 * CAPACITY;
    localparam int N_PRE          = 30;
    localparam int N_POST         = 40;
    localparam int TIMEOUT_CYCLES = 20 * (N_FREE + N_BACK + N_FILL + N_PRE + N_POST);
    localparam int READY_HIGH     = 0;
    localparam int READY_RANDOM   = 1;
    localparam int READY_LOW      = 2;

    logic             clk = 1'b0;
    logic             rstReadAddr;
    logic             in_valid;
    logic             in_ready;
    logic [WIDTH-1:0] in_data;
    logic             out_valid;
    logic             out_ready;
    logic [WIDTH-1:0] out_data;

    // Words accepted at the input and not yet seen at the output
    logic [WIDTH-1:0] expected [$];
    string            test_name   = "reset";
    int               ready_mode  = READY_LOW;
    int               out_count   = 0;
    int               cycle_count = 0;
    int               fill_count;

    banked_fifo_top #(
        .WIDTH            (WIDTH),
        .DEPTH_LOG2       (DEPTH_LOG2),
        .LANES_LOG2       (LANES_LOG2),
        .OUTPUT_REGISTER  (1),
        .READ_DURING_WRITE(RDW_OLD_DATA)
    ) uut (
        .clk        (clk),
        .rstReadAddr(rstReadAddr),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

    always #2 clk = ~clk;

    // Output back-pressure
    always @(negedge clk) begin
        case (ready_mode)
            READY_HIGH:   out_ready = 1'b1;
            READY_RANDOM: out_ready = ($urandom_range(99) < 60);
            default:      out_ready = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("ERROR: %s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // FIFO order is kept across all lanes, so the oldest word is next
    function automatic logic [WIDTH-1:0] model_pop();
        logic [WIDTH-1:0] word;
        word = expected.pop_front();
        return word;
    endfunction

    always @(posedge clk) begin
        if (!rstReadAddr) begin
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    stop_with_error($sformatf("output word %h appeared with no word pending",
                                              out_data));
                end else begin
                    check_value(test_name, 32'(model_pop()), 32'(out_data));
                end
                out_count = out_count + 1;
            end
            if (in_valid && in_ready) begin
                expected.push_back(in_data);
            end
        end
    end

    task automatic reset_dut();
        rstReadAddr = 1'b1;
        in_valid    = 1'b0;
        expected.delete();
        repeat (10) @(negedge clk);
        rstReadAddr = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        out_count = 0;
    endtask

    task automatic send_word(input logic [WIDTH-1:0] word);
        in_valid = 1'b1;
        in_data  = word;
        // Ready is stable here, so it decides the next rising edge
        while (!in_ready) @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_stream(input int count, input int gap_pct);
        for (int i = 0; i < count; i++) begin
            while ($urandom_range(99) < gap_pct) @(negedge clk);
            send_word(WIDTH'($urandom()));
        end
    endtask

    task automatic wait_drain(input int sent);
        while (expected.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk);
        check_value({test_name, " word count"}, 32'(sent), 32'(out_count));
    endtask

    initial begin
        void'($urandom(19478));
        rstReadAddr = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        @(negedge clk);
        reset_dut();
        check_value("reset out_valid", 32'd0, 32'(out_valid));
        check_value("reset in_ready", 32'd1, 32'(in_ready));

        start_test("free_flow");
        ready_mode = READY_HIGH;
        send_stream(N_FREE, 20);
        wait_drain(N_FREE);

        start_test("back_pressure");
        ready_mode = READY_RANDOM;
        send_stream(N_BACK, 10);
        wait_drain(N_BACK);

        // Output blocked, every lane fills up
        start_test("fill");
        ready_mode = READY_LOW;
        repeat (2) @(negedge clk);
        fill_count = 0;
        while (in_ready && fill_count < N_FILL) begin
            in_valid = 1'b1;
            in_data  = WIDTH'($urandom());
            @(negedge clk);
            fill_count = fill_count + 1;
        end
        in_valid = 1'b0;
        if (in_ready) begin
            stop_with_error("in_ready never dropped while the output was blocked");
        end
        if (fill_count < CAPACITY) begin
            stop_with_error($sformatf("only %0d words accepted before in_ready dropped",
                                      fill_count));
        end
        ready_mode = READY_HIGH;
        wait_drain(fill_count);

        // Words still inside the lanes are thrown away
        start_test("mid_reset");
        send_stream(N_PRE, 0);
        reset_dut();
        repeat (20) begin
            check_value("mid_reset out_valid", 32'd0, 32'(out_valid));
            @(negedge clk);
        end
        check_value("mid_reset in_ready", 32'd1, 32'(in_ready));

        start_test("after_reset");
        send_stream(N_POST, 20);
        wait_drain(N_POST);

        $display("TESTBENCH PASSED");
        $finish;
    end
endmodule

// File: flist.f
hw/mem_cfg_pkg.sv
hw/stream_pkg.sv
hw/lane_if.sv
hw/memory_mlab.sv
hw/lane_fifo.sv
hw/lane_distributor.sv
hw/lane_collector.sv
hw/banked_fifo_top.sv
testbench/tb_banked_fifo.sv

// File: Makefile
TOP := tb_banked_fifo

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
